// File: bp_cfg_pkg.sv
package bp_cfg_pkg;

	// ################################################
	// Table geometry
	// ################################################

	// History bits, one weight per bit plus the bias weight
	localparam int HIST_LEN = 8;

	// Signed width of a single weight
	localparam int WEIGHT_W = 8;

	// The table holds 2**TABLE_IDX_W rows, indexed by the low PC bits
	localparam int TABLE_IDX_W = 4;

	localparam int PC_W = 32;

	// ################################################
	// Training
	// ################################################

	// Queue entries, equal to the credits the sender starts with
	localparam int RESOLVE_DEPTH = 4;

	// Threshold of 1.93 * HIST_LEN + 14, truncated to an integer
	localparam int THETA = (193 * HIST_LEN + 1400) / 100;

endpackage

// File: bp_types_pkg.sv
package bp_types_pkg;

	import bp_cfg_pkg::*;

	// ################################################
	// Weights and history
	// ################################################

	typedef logic signed [WEIGHT_W-1:0] weight_t;

	// Entry 0 is the bias, entry i+1 pairs with history bit i
	typedef weight_t weight_row_t [HIST_LEN+1];

	// Bit 0 holds the most recent outcome
	typedef logic [HIST_LEN-1:0] hist_t;

	// Nine saturated weights fit in four extra bits
	typedef logic signed [WEIGHT_W+3:0] sum_t;

	// ################################################
	// Resolve records
	// ################################################

	typedef struct packed {
		logic [PC_W-1:0] pc;
		logic taken;
		logic cond;
	} resolve_rec_t;

endpackage

// File: perceptron_ctrl.sv
module perceptron_ctrl #(
	parameter int HIST_LEN = bp_cfg_pkg::HIST_LEN,
	parameter int TABLE_IDX_W = bp_cfg_pkg::TABLE_IDX_W,
	parameter int RESOLVE_DEPTH = bp_cfg_pkg::RESOLVE_DEPTH
) (
	input logic clk,
	input logic rst,
	input logic predict_vld_i,
	input logic resolve_vld_i,
	input bp_types_pkg::resolve_rec_t resolve_rec_i,
	output bp_types_pkg::hist_t hist_o,
	output bp_types_pkg::weight_row_t train_row_o,
	output bp_types_pkg::hist_t train_hist_o,
	output logic train_taken_o,
	input bp_types_pkg::sum_t train_sum_i,
	input bp_types_pkg::weight_row_t new_row_i,
	input logic train_i,
	output logic pred_vld_o,
	output logic resolve_credit_o,
	weight_port_if.trainer wp
);
	import bp_types_pkg::*;

	localparam int PTR_W = (RESOLVE_DEPTH > 1) ? $clog2(RESOLVE_DEPTH) : 1;
	localparam int CNT_W = $clog2(RESOLVE_DEPTH + 1);

	typedef enum logic [1:0] {IDLE, READ, WRITE} state_t;

	state_t state;
	state_t state_nxt;
	resolve_rec_t queue [RESOLVE_DEPTH];
	resolve_rec_t cur_rec;
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_nxt;
	hist_t bhr;
	logic commit;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(RESOLVE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// ################################################
	// Resolve queue and history
	// ################################################

	// The sender never pushes into a full queue because it holds no credit then
	always_ff @(posedge clk) begin
		if (resolve_vld_i) begin
			queue[tail] <= resolve_rec_i;
		end
		if (state == READ) begin
			cur_rec <= queue[head];
		end
		if (predict_vld_i) begin
			hist_o <= bhr;
		end
	end

	// A record counts as queued until its credit goes back
	assign count_nxt = count + CNT_W'(resolve_vld_i) - CNT_W'(resolve_credit_o);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			head <= '0;
			tail <= '0;
			count <= '0;
			bhr <= '0;
			pred_vld_o <= 1'b0;
		end else begin
			state <= state_nxt;
			count <= count_nxt;
			pred_vld_o <= predict_vld_i;
			if (resolve_vld_i) begin
				tail <= ptr_inc(tail);
			end
			if (state == READ) begin
				head <= ptr_inc(head);
			end
			if (state == WRITE && cur_rec.cond) begin
				bhr <= {bhr[HIST_LEN-2:0], cur_rec.taken};
			end
		end
	end

	// ################################################
	// Training sequencer
	// ################################################

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (count != '0) begin
					state_nxt = READ;
				end
			end
			READ: state_nxt = WRITE;
			WRITE: state_nxt = (count_nxt != '0) ? READ : IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	assign wp.rd_en = (state == READ);
	assign wp.rd_idx = queue[head].pc[TABLE_IDX_W-1:0];

	// The row arrives in WRITE and is scored against the current history
	assign train_row_o = wp.rd_row;
	assign train_hist_o = bhr;
	assign train_taken_o = cur_rec.taken;

	assign commit = cur_rec.cond && train_i;

	assign wp.wr_en = (state == WRITE) && commit;
	assign wp.wr_idx = cur_rec.pc[TABLE_IDX_W-1:0];
	assign wp.wr_row = new_row_i;

	assign resolve_credit_o = (state == WRITE);

endmodule

// File: perceptron_dot.sv
module perceptron_dot #(
	parameter int HIST_LEN = bp_cfg_pkg::HIST_LEN
) (
	input bp_types_pkg::weight_row_t row_i,
	input bp_types_pkg::hist_t hist_i,
	output bp_types_pkg::sum_t sum_o,
	output logic taken_o
);
	import bp_types_pkg::*;

	// History bits act as +1 for taken and -1 for not taken
	always_comb begin
		sum_t acc;

		acc = sum_t'(row_i[0]);
		for (int i = 0; i < HIST_LEN; i++) begin
			if (hist_i[i]) begin
				acc = acc + sum_t'(row_i[i+1]);
			end else begin
				acc = acc - sum_t'(row_i[i+1]);
			end
		end
		sum_o = acc;
	end

	// A zero sum counts as taken
	assign taken_o = (sum_o >= 0);

endmodule

// File: perceptron_predictor.sv
module perceptron_predictor #(
	parameter int HIST_LEN = bp_cfg_pkg::HIST_LEN,
	parameter int WEIGHT_W = bp_cfg_pkg::WEIGHT_W,
	parameter int TABLE_IDX_W = bp_cfg_pkg::TABLE_IDX_W,
	parameter int PC_W = bp_cfg_pkg::PC_W,
	parameter int RESOLVE_DEPTH = bp_cfg_pkg::RESOLVE_DEPTH,
	parameter int THETA = bp_cfg_pkg::THETA
) (
	input logic clk,
	input logic rst,
	input logic predict_vld_i,
	input logic [PC_W-1:0] predict_pc_i,
	input logic resolve_vld_i,
	input logic [PC_W-1:0] resolve_pc_i,
	input logic resolve_taken_i,
	input logic resolve_cond_i,
	output logic pred_vld_o,
	output logic pred_taken_o,
	output logic resolve_credit_o
);
	import bp_types_pkg::*;

	resolve_rec_t resolve_rec;
	hist_t pred_hist;
	hist_t train_hist;
	weight_row_t pred_row;
	weight_row_t train_row;
	weight_row_t new_row;
	sum_t train_sum;
	logic train_taken;
	logic train_needed;

	weight_port_if #(.TABLE_IDX_W(TABLE_IDX_W)) wp_if ();

	assign resolve_rec = '{pc: resolve_pc_i, taken: resolve_taken_i, cond: resolve_cond_i};

	perceptron_ctrl #(
		.HIST_LEN(HIST_LEN),
		.TABLE_IDX_W(TABLE_IDX_W),
		.RESOLVE_DEPTH(RESOLVE_DEPTH)
	) u_perceptron_ctrl (
		.clk(clk),
		.rst(rst),
		.predict_vld_i(predict_vld_i),
		.resolve_vld_i(resolve_vld_i),
		.resolve_rec_i(resolve_rec),
		.hist_o(pred_hist),
		.train_row_o(train_row),
		.train_hist_o(train_hist),
		.train_taken_o(train_taken),
		.train_sum_i(train_sum),
		.new_row_i(new_row),
		.train_i(train_needed),
		.pred_vld_o(pred_vld_o),
		.resolve_credit_o(resolve_credit_o),
		.wp(wp_if)
	);

	weight_table #(.TABLE_IDX_W(TABLE_IDX_W)) u_weight_table (
		.clk(clk),
		.rst(rst),
		.pred_rd_en_i(predict_vld_i),
		.pred_rd_idx_i(predict_pc_i[TABLE_IDX_W-1:0]),
		.pred_rd_row_o(pred_row),
		.tp(wp_if)
	);

	// Row and history are both registered on the request edge
	perceptron_dot #(.HIST_LEN(HIST_LEN)) u_pred_dot (
		.row_i(pred_row),
		.hist_i(pred_hist),
		.sum_o(),
		.taken_o(pred_taken_o)
	);

	perceptron_dot #(.HIST_LEN(HIST_LEN)) u_train_dot (
		.row_i(train_row),
		.hist_i(train_hist),
		.sum_o(train_sum),
		.taken_o()
	);

	weight_update #(
		.HIST_LEN(HIST_LEN),
		.WEIGHT_W(WEIGHT_W),
		.THETA(THETA)
	) u_weight_update (
		.row_i(train_row),
		.hist_i(train_hist),
		.sum_i(train_sum),
		.outcome_i(train_taken),
		.row_o(new_row),
		.train_o(train_needed)
	);

endmodule

// File: perceptron_properties.sv
module perceptron_properties #(
	parameter int RESOLVE_DEPTH = bp_cfg_pkg::RESOLVE_DEPTH,
	parameter int CNT_W = 3
) (
	input logic clk,
	input logic rst,
	input logic predict_vld_i,
	input logic pred_vld_i,
	input logic credit_i,
	input logic [CNT_W-1:0] count_i,
	input logic in_write_i,
	input logic wr_en_i
);
	timeunit 1ns;
	timeprecision 100ps;

	int error_count = 0;

	// ##################################################
	// Queue and credit rules
	// ##################################################

	// A push without a credit would overfill the queue
	assert property (@(posedge clk) disable iff (rst) count_i <= RESOLVE_DEPTH)
	else begin
		$error("resolve queue count above its depth");
		error_count++;
	end

	assert property (@(posedge clk) disable iff (rst) credit_i |-> count_i != '0)
	else begin
		$error("credit returned while the resolve queue is empty");
		error_count++;
	end

	assert property (@(posedge clk) disable iff (rst) pred_vld_i == $past(predict_vld_i))
	else begin
		$error("prediction valid does not follow the request by one cycle");
		error_count++;
	end

	assert property (@(posedge clk) disable iff (rst) wr_en_i |-> in_write_i)
	else begin
		$error("weight write outside the WRITE state");
		error_count++;
	end

endmodule

bind perceptron_ctrl perceptron_properties #(
	.RESOLVE_DEPTH(RESOLVE_DEPTH),
	.CNT_W(CNT_W)
) u_perceptron_properties (
	.clk(clk),
	.rst(rst),
	.predict_vld_i(predict_vld_i),
	.pred_vld_i(pred_vld_o),
	.credit_i(resolve_credit_o),
	.count_i(count),
	.in_write_i(state == WRITE),
	.wr_en_i(wp.wr_en)
);

// File: tb_perceptron.sv
module tb_perceptron;
	timeunit 1ns;
	timeprecision 100ps;

	import bp_cfg_pkg::*;

	localparam int ROWS = 2 ** TABLE_IDX_W;
	localparam int TIMEOUT = 200;
	localparam int W_MAX = (2 ** (WEIGHT_W - 1)) - 1;
	localparam int W_MIN = -(2 ** (WEIGHT_W - 1));

	logic clk;
	logic rst;
	logic predict_vld_i;
	logic [PC_W-1:0] predict_pc_i;
	logic resolve_vld_i;
	logic [PC_W-1:0] resolve_pc_i;
	logic resolve_taken_i;
	logic resolve_cond_i;
	logic pred_vld_o;
	logic pred_taken_o;
	logic resolve_credit_o;

	int seed;
	int sent;
	int returned;
	int model_w [ROWS][HIST_LEN+1];
	logic [HIST_LEN-1:0] model_bhr;

	perceptron_predictor u_perceptron_predictor (.*);

	always #20 clk = ~clk;

	// ##################################################
	// Checks and reference model
	// ##################################################

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	// Each credit pulse must belong to a record that is still outstanding
	always @(posedge clk) begin
		if (!rst && resolve_credit_o) begin
			check_value("credit without record", 1, returned < sent);
			returned <= returned + 1;
		end
	end

	function automatic int model_sum(input int idx);
		int s;
		s = model_w[idx][0];
		for (int i = 0; i < HIST_LEN; i++) begin
			s += model_bhr[i] ? model_w[idx][i+1] : -model_w[idx][i+1];
		end
		return s;
	endfunction

	function automatic int sat_step(input int w, input logic up);
		if (up) begin
			return (w < W_MAX) ? w + 1 : w;
		end
		return (w > W_MIN) ? w - 1 : w;
	endfunction

	task automatic model_train(input logic [PC_W-1:0] pc, input logic taken, input logic cond);
		int idx;
		int s;
		idx = pc[TABLE_IDX_W-1:0];
		if (!cond) begin
			return;
		end
		s = model_sum(idx);
		if (((s >= 0) != taken) || (s <= THETA && s >= -THETA)) begin
			model_w[idx][0] = sat_step(model_w[idx][0], taken);
			for (int i = 0; i < HIST_LEN; i++) begin
				model_w[idx][i+1] = sat_step(model_w[idx][i+1], model_bhr[i] == taken);
			end
		end
		model_bhr = {model_bhr[HIST_LEN-2:0], taken};
	endtask

	// ##################################################
	// Stimulus
	// ##################################################

	task automatic check_prediction(input logic [PC_W-1:0] pc, input string name);
		int waited;
		logic expected;
		expected = (model_sum(pc[TABLE_IDX_W-1:0]) >= 0);
		@(posedge clk);
		predict_vld_i <= 1'b1;
		predict_pc_i <= pc;
		@(posedge clk);
		predict_vld_i <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (!pred_vld_o) begin
			waited++;
			if (waited > TIMEOUT) begin
				$display("ERROR: no prediction came back for %s", name);
				abort_run();
			end
			@(negedge clk);
		end
		check_value(name, expected, pred_taken_o);
	endtask

	// The sender spends one credit per record and waits while it holds none
	task automatic send_resolve(input logic [PC_W-1:0] pc, input logic taken, input logic cond);
		int waited;
		waited = 0;
		@(posedge clk);
		resolve_vld_i <= 1'b0;
		while (sent - returned >= RESOLVE_DEPTH) begin
			waited++;
			if (waited > TIMEOUT) begin
				$display("ERROR: no credit came back for a waiting resolve record");
				abort_run();
			end
			@(posedge clk);
		end
		resolve_vld_i <= 1'b1;
		resolve_pc_i <= pc;
		resolve_taken_i <= taken;
		resolve_cond_i <= cond;
		sent++;
		model_train(pc, taken, cond);
	endtask

	task automatic end_burst();
		@(posedge clk);
		resolve_vld_i <= 1'b0;
	endtask

	task automatic wait_credits(input string name);
		int waited;
		waited = 0;
		while (sent != returned) begin
			waited++;
			if (waited > TIMEOUT) begin
				$display("ERROR: credits did not return during %s", name);
				abort_run();
			end
			@(posedge clk);
		end
	endtask

	task automatic check_table(input string name);
		for (int idx = 0; idx < ROWS; idx++) begin
			check_prediction({$random(seed)} << TABLE_IDX_W | idx, name);
		end
	endtask

	initial begin
		int n;
		int idx;
		seed = 32'hc7f2d35d;
		clk = 1'b0;
		rst = 1'b1;
		predict_vld_i = 1'b0;
		predict_pc_i = '0;
		resolve_vld_i = 1'b0;
		resolve_pc_i = '0;
		resolve_taken_i = 1'b0;
		resolve_cond_i = 1'b0;
		sent = 0;
		returned = 0;
		model_bhr = '0;
		model_w = '{default: '{default: 0}};
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// Zero weights give a zero sum, which predicts taken
		for (int k = 0; k < 8; k++) begin
			check_prediction($random(seed), "reset prediction");
		end

		for (int b = 0; b < 8; b++) begin
			n = 1 + $unsigned($random(seed)) % (RESOLVE_DEPTH + 2);
			for (int j = 0; j < n; j++) begin
				send_resolve($random(seed), $random(seed), $random(seed));
			end
			end_burst();
		end
		wait_credits("burst credits");
		check_table("burst prediction");

		for (int t = 0; t < 80; t++) begin
			idx = ($unsigned($random(seed)) % 4) * 4 + 1;
			send_resolve({$random(seed)} << TABLE_IDX_W | idx, $random(seed), 1'b1);
		end
		end_burst();
		wait_credits("training credits");
		check_table("trained prediction");

		for (int t = 0; t < 20; t++) begin
			send_resolve($random(seed), $random(seed), 1'b0);
		end
		end_burst();
		wait_credits("unconditional credits");
		check_table("unconditional prediction");

		// Long runs of one outcome push the sum past the threshold
		for (int t = 0; t < 150; t++) begin
			send_resolve(32'h0000_1003, 1'b1, 1'b1);
		end
		for (int t = 0; t < 150; t++) begin
			send_resolve(32'h0000_2007, 1'b0, 1'b1);
		end
		end_burst();
		wait_credits("saturation credits");
		check_table("saturation prediction");

		if (u_perceptron_predictor.u_perceptron_ctrl.u_perceptron_properties.error_count != 0) begin
			$display("ERROR: assertions on the control module failed");
			abort_run();
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// File: verilog.f
bp_cfg_pkg.sv
bp_types_pkg.sv
weight_port_if.sv
weight_table.sv
perceptron_dot.sv
weight_update.sv
perceptron_ctrl.sv
perceptron_predictor.sv
perceptron_properties.sv
tb_perceptron.sv

// File: weight_port_if.sv
interface weight_port_if #(
	parameter int TABLE_IDX_W = bp_cfg_pkg::TABLE_IDX_W
);
	import bp_types_pkg::*;

	// Training read, the row returns one cycle after rd_en
	logic rd_en;
	logic [TABLE_IDX_W-1:0] rd_idx;
	weight_row_t rd_row;

	// Training write, applied at the clock edge
	logic wr_en;
	logic [TABLE_IDX_W-1:0] wr_idx;
	weight_row_t wr_row;

	modport trainer (
		output rd_en, rd_idx, wr_en, wr_idx, wr_row,
		input rd_row
	);

	modport tbl (
		input rd_en, rd_idx, wr_en, wr_idx, wr_row,
		output rd_row
	);

endinterface

// File: weight_table.sv
module weight_table #(
	parameter int TABLE_IDX_W = bp_cfg_pkg::TABLE_IDX_W
) (
	input logic clk,
	input logic rst,
	input logic pred_rd_en_i,
	input logic [TABLE_IDX_W-1:0] pred_rd_idx_i,
	output bp_types_pkg::weight_row_t pred_rd_row_o,
	weight_port_if.tbl tp
);
	import bp_types_pkg::*;

	localparam int ROWS = 2 ** TABLE_IDX_W;

	weight_row_t rows [ROWS];

	// All weights start at zero so every first prediction is taken
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < ROWS; r++) begin
				rows[r] <= '{default: '0};
			end
		end else if (tp.wr_en) begin
			rows[tp.wr_idx] <= tp.wr_row;
		end
	end

	// ################################################
	// Registered read ports
	// ################################################

	// Reads on the edge of a write still see the old row
	always_ff @(posedge clk) begin
		if (pred_rd_en_i) begin
			pred_rd_row_o <= rows[pred_rd_idx_i];
		end
	end

	always_ff @(posedge clk) begin
		if (tp.rd_en) begin
			tp.rd_row <= rows[tp.rd_idx];
		end
	end

endmodule

// File: weight_update.sv
module weight_update #(
	parameter int HIST_LEN = bp_cfg_pkg::HIST_LEN,
	parameter int WEIGHT_W = bp_cfg_pkg::WEIGHT_W,
	parameter int THETA = bp_cfg_pkg::THETA
) (
	input bp_types_pkg::weight_row_t row_i,
	input bp_types_pkg::hist_t hist_i,
	input bp_types_pkg::sum_t sum_i,
	input logic outcome_i,
	output bp_types_pkg::weight_row_t row_o,
	output logic train_o
);
	import bp_types_pkg::*;

	localparam weight_t W_MAX = weight_t'((2 ** (WEIGHT_W - 1)) - 1);
	localparam weight_t W_MIN = weight_t'(-(2 ** (WEIGHT_W - 1)));

	logic sum_taken;
	logic low_margin;

	// Train on a wrong direction or while the sum sits inside the threshold
	assign sum_taken = (sum_i >= 0);
	assign low_margin = (sum_i <= sum_t'(THETA)) && (sum_i >= -sum_t'(THETA));
	assign train_o = (sum_taken != outcome_i) || low_margin;

	// One step towards the outcome, held at the signed limits
	function automatic weight_t step(input weight_t w, input logic up);
		if (up) begin
			return (w == W_MAX) ? w : weight_t'(w + 1);
		end
		return (w == W_MIN) ? w : weight_t'(w - 1);
	endfunction

	always_comb begin
		row_o[0] = step(row_i[0], outcome_i);
		for (int i = 0; i < HIST_LEN; i++) begin
			row_o[i+1] = step(row_i[i+1], hist_i[i] == outcome_i);
		end
	end

endmodule
